//--- flist.f
+incdir+src
src/axil_pkg.sv
src/axil_write_channel.sv
src/axil_read_channel.sv
src/reg_bank.sv
src/axil_reg_demo.sv
bench/tb_clock_gen.sv
bench/tb_axil_reg_demo.sv

//--- bench/tb_axil_reg_demo.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module tb_axil_reg_demo
  import axil_pkg::*;
();

  localparam int         TIMEOUT_CYCLES = 4000;
  localparam axil_resp_t RESP_OKAY = axil_resp_t'(`AXIL_RESP_OKAY);

  logic       S_AXI_ACLK;
  logic       S_AXI_ARESETN;
  axil_addr_t s_axi_awaddr;
  logic       s_axi_awvalid;
  logic       s_axi_awready;
  axil_data_t s_axi_wdata;
  axil_strb_t s_axi_wstrb;
  logic       s_axi_wvalid;
  logic       s_axi_wready;
  axil_resp_t s_axi_bresp;
  logic       s_axi_bvalid;
  logic       s_axi_bready;
  axil_addr_t s_axi_araddr;
  logic       s_axi_arvalid;
  logic       s_axi_arready;
  axil_data_t s_axi_rdata;
  axil_resp_t s_axi_rresp;
  logic       s_axi_rvalid;
  logic       s_axi_rready;

  axil_data_t  model [`AXIL_REG_COUNT];
  logic [31:0] lfsr_state;
  logic        rand_ready;  // when low the master always takes responses at once
  int          err_count;
  int          err_mark;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count = 0;
  logic        w_start;
  logic        r_start;

  tb_clock_gen u_clock_gen (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN));

  axil_reg_demo dut (.*);

  ////////////////////////////////
  // protocol checks
  ////////////////////////////////

  assign w_start = s_axi_awvalid && s_axi_wvalid && !s_axi_awready &&
                   (!s_axi_bvalid || s_axi_bready);
  assign r_start = s_axi_arvalid && !s_axi_arready && (!s_axi_rvalid || s_axi_rready);

  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid |-> s_axi_bresp == RESP_OKAY)
    else begin
      $display("[ERROR] s_axi_bresp expected %h got %h", RESP_OKAY, s_axi_bresp);
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid |-> s_axi_rresp == RESP_OKAY)
    else begin
      $display("[ERROR] s_axi_rresp expected %h got %h", RESP_OKAY, s_axi_rresp);
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && !$rose(s_axi_awready))
    else begin
      $display("write response dropped or new write accepted while bready was low");
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rdata) && !$rose(s_axi_arready))
    else begin
      $display("read data changed or new read accepted while rready was low");
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_awready == s_axi_wready)
    else begin
      $display("awready and wready differ");
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    w_start |-> ##2 $rose(s_axi_bvalid))
    else begin
      $display("bvalid did not rise two cycles after the write started");
      err_count++;
    end
  assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    r_start |-> ##2 $rose(s_axi_rvalid))
    else begin
      $display("rvalid did not rise two cycles after the read started");
      err_count++;
    end

  always @(posedge S_AXI_ACLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic take_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic logic pick_ready();
    return rand_ready ? take_bit() : 1'b1;
  endfunction

  function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                             input axil_data_t new_word,
                                             input axil_strb_t strb);
    axil_data_t m;
    m = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return m;
  endfunction

  task automatic check_word(input string name, input axil_data_t exp, input axil_data_t got);
    assert (got === exp) else begin
      $display("[ERROR] %s expected %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic take_response();  // called while bvalid is high
    s_axi_bready = pick_ready();
    while (!s_axi_bready) begin
      @(negedge S_AXI_ACLK);
      s_axi_bready = pick_ready();
    end
    @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b0;
  endtask

  // address and data handshake only, the response stays with the caller
  task automatic issue_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
    @(negedge S_AXI_ACLK);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_awready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);  // handshake done on the edge before
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    model[addr[6:2]] = merge_bytes(model[addr[6:2]], data, strb);
  endtask

  task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    issue_write(addr, data, strb);
    take_response();
  endtask

  task automatic check_read(input axil_addr_t addr);
    axil_data_t got;
    @(negedge S_AXI_ACLK);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_arready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    s_axi_arvalid = 1'b0;
    s_axi_rready  = pick_ready();
    while (!s_axi_rready) begin
      @(negedge S_AXI_ACLK);
      s_axi_rready = pick_ready();
    end
    got = s_axi_rdata;
    @(negedge S_AXI_ACLK);
    s_axi_rready = 1'b0;
    check_word("s_axi_rdata", model[addr[6:2]], got);
  endtask

  task automatic end_test(input string name);
    if (err_count == err_mark) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////

  initial begin
    logic [31:0] rnd;
    lfsr_state    = 32'h97b1;
    rand_ready    = 1'b0;
    err_count     = 0;
    err_mark      = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    for (int i = 0; i < `AXIL_REG_COUNT; i++) model[i] = '0;
    @(posedge S_AXI_ARESETN);

    @(negedge S_AXI_ACLK);
    assert (!(s_axi_awready || s_axi_wready || s_axi_bvalid ||
              s_axi_arready || s_axi_rvalid)) else begin
      $display("a ready or valid output is high after reset");
      err_count++;
    end
    for (int i = 0; i < `AXIL_REG_COUNT; i++) check_read(axil_addr_t'(i * 4));
    end_test("reset");

    for (int i = 0; i < `AXIL_REG_COUNT; i++) write_word(axil_addr_t'(i * 4), take_bits(32), 4'hf);
    for (int i = 0; i < `AXIL_REG_COUNT; i++) check_read(axil_addr_t'(i * 4));
    end_test("full-word writes");

    for (int s = 1; s < 15; s++) begin  // every partial strobe pattern
      write_word(axil_addr_t'(s * 4), take_bits(32), axil_strb_t'(s));
      check_read(axil_addr_t'(s * 4));
    end
    end_test("byte strobes");

    // first response is left pending while a second write waits
    issue_write(7'h40, 32'h0bad_f00d, 4'hf);
    @(negedge S_AXI_ACLK);
    s_axi_awaddr  = 7'h44;
    s_axi_wdata   = 32'h1234_5678;
    s_axi_wstrb   = 4'hf;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b0;
    repeat (4) @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_awready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    model[5'h11] = 32'h1234_5678;
    take_response();
    check_read(7'h40);
    check_read(7'h44);
    end_test("write back-pressure");

    @(negedge S_AXI_ACLK);
    s_axi_araddr  = 7'h0c;
    s_axi_arvalid = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_arready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    s_axi_arvalid = 1'b0;
    @(negedge S_AXI_ACLK);
    s_axi_araddr  = 7'h10;  // waits behind the unread data
    s_axi_arvalid = 1'b1;
    repeat (4) @(negedge S_AXI_ACLK);
    check_word("s_axi_rdata", model[3], s_axi_rdata);
    s_axi_rready = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!s_axi_arready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    s_axi_arvalid = 1'b0;
    check_word("s_axi_rdata", model[4], s_axi_rdata);
    @(negedge S_AXI_ACLK);
    s_axi_rready = 1'b0;
    end_test("read back-pressure");

    rand_ready = 1'b1;
    repeat (200) begin
      rnd = take_bits(7);
      if (take_bit()) write_word(rnd[6:0], take_bits(32), axil_strb_t'(take_bits(4)));
      else check_read(rnd[6:0]);
    end
    end_test("random traffic");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  localparam real HALF_PERIOD = 20.0;  // 40 ns clock
  localparam int  RESET_CYCLES = 8;

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #(HALF_PERIOD) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // release on a falling edge, like every other input of the DUT
  initial begin
    S_AXI_ARESETN = 1'b0;
    repeat (RESET_CYCLES) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
  end

endmodule

//--- src/axil_reg_demo.sv
`timescale 1ns/1ps

module axil_reg_demo
  import axil_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  // write address
  input  axil_addr_t s_axi_awaddr,
  input  logic       s_axi_awvalid,
  output logic       s_axi_awready,
  // write data
  input  axil_data_t s_axi_wdata,
  input  axil_strb_t s_axi_wstrb,
  input  logic       s_axi_wvalid,
  output logic       s_axi_wready,
  // write response
  output axil_resp_t s_axi_bresp,
  output logic       s_axi_bvalid,
  input  logic       s_axi_bready,
  // read address
  input  axil_addr_t s_axi_araddr,
  input  logic       s_axi_arvalid,
  output logic       s_axi_arready,
  // read data
  output axil_data_t s_axi_rdata,
  output axil_resp_t s_axi_rresp,
  output logic       s_axi_rvalid,
  input  logic       s_axi_rready
);

  reg_write_t wr_cmd;
  logic       wr_en;     // one-cycle pulse per accepted write
  reg_index_t rd_index;
  axil_data_t rd_word;

  ////////////////////////////////
  // channels and register bank
  ////////////////////////////////

  axil_write_channel u_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_cmd        (wr_cmd),
    .wr_en         (wr_en)
  );

  axil_read_channel u_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_index      (rd_index),
    .rd_word       (rd_word)
  );

  reg_bank u_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_cmd        (wr_cmd),
    .wr_en         (wr_en),
    .rd_index      (rd_index),
    .rd_word       (rd_word)
  );

endmodule

//--- src/reg_bank.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module reg_bank
  import axil_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  reg_write_t wr_cmd,
  input  logic       wr_en,
  input  reg_index_t rd_index,
  output axil_data_t rd_word
);

  axil_data_t regs [`AXIL_REG_COUNT];

  ////////////////////////////////
  // byte-strobe writes
  ////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      // bytes with a clear strobe keep their old value
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (wr_cmd.strb[b]) begin
          regs[wr_cmd.index][b*8 +: 8] <= wr_cmd.data[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////
  // read select
  ////////////////////////////////

  // the index spans exactly the register count so every value is a register
  assign rd_word = regs[rd_index];

endmodule

//--- src/axil_read_channel.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_read_channel
  import axil_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  axil_addr_t s_axi_araddr,
  input  logic       s_axi_arvalid,
  output logic       s_axi_arready,
  output axil_data_t s_axi_rdata,
  output axil_resp_t s_axi_rresp,
  output logic       s_axi_rvalid,
  input  logic       s_axi_rready,
  output reg_index_t rd_index,
  input  axil_data_t rd_word
);

  logic       arready_q;
  logic       rvalid_q;
  logic       rd_accept;
  axil_data_t rdata_q;

  ////////////////////////////////
  // read address acceptance
  ////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= !arready_q && s_axi_arvalid && (!rvalid_q || s_axi_rready);
    end
  end

  assign s_axi_arready = arready_q;
  assign rd_accept     = arready_q && s_axi_arvalid;

  // the bank answers in the same cycle
  assign rd_index = s_axi_araddr[`AXIL_ADDR_W-1:`AXIL_ADDR_LSB];

  ////////////////////////////////
  // read data
  ////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
      rdata_q  <= rd_word;  // loaded only on an accepted read
    end else if (s_axi_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  assign s_axi_rvalid = rvalid_q;
  assign s_axi_rdata  = rdata_q;
  assign s_axi_rresp  = axil_resp_t'(`AXIL_RESP_OKAY);

endmodule

//--- src/axil_write_channel.sv
`timescale 1ns/1ps
`include "axil_consts.svh"

module axil_write_channel
  import axil_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  axil_addr_t s_axi_awaddr,
  input  logic       s_axi_awvalid,
  output logic       s_axi_awready,
  input  axil_data_t s_axi_wdata,
  input  axil_strb_t s_axi_wstrb,
  input  logic       s_axi_wvalid,
  output logic       s_axi_wready,
  output axil_resp_t s_axi_bresp,
  output logic       s_axi_bvalid,
  input  logic       s_axi_bready,
  output reg_write_t wr_cmd,
  output logic       wr_en
);

  logic accept_q;  // shared by awready and wready
  logic bvalid_q;
  logic slot_free;

  // a new write may only start when the response slot can take it
  assign slot_free = !bvalid_q || s_axi_bready;

  ////////////////////////////////
  // address and data acceptance
  ////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      accept_q <= 1'b0;
    end else begin
      // both channels must be valid together, pulse lasts one cycle
      accept_q <= !accept_q && s_axi_awvalid && s_axi_wvalid && slot_free;
    end
  end

  assign s_axi_awready = accept_q;
  assign s_axi_wready  = accept_q;

  assign wr_en = accept_q && s_axi_awvalid && s_axi_wvalid;

  // the master holds address and data stable during the ready cycle
  always_comb begin
    wr_cmd.index = s_axi_awaddr[`AXIL_ADDR_W-1:`AXIL_ADDR_LSB];
    wr_cmd.data  = s_axi_wdata;
    wr_cmd.strb  = s_axi_wstrb;
  end

  ////////////////////////////////
  // write response
  ////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid_q <= 1'b0;
    end else if (wr_en) begin
      bvalid_q <= 1'b1;  // slot is always empty here
    end else if (s_axi_bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign s_axi_bvalid = bvalid_q;
  assign s_axi_bresp  = axil_resp_t'(`AXIL_RESP_OKAY);  // every write succeeds

endmodule

//--- src/axil_pkg.sv
`include "axil_consts.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;   // byte address
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;   // one bit per byte lane
  typedef logic [1:0]              axil_resp_t;

  // register number, address bits 6 down to 2
  typedef logic [$clog2(`AXIL_REG_COUNT)-1:0] reg_index_t;

  // one register write as it leaves the write channel
  typedef struct packed {
    reg_index_t index;
    axil_data_t data;
    axil_strb_t strb;
  } reg_write_t;

endpackage

//--- src/axil_consts.svh
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

// byte address covers 32 words of 4 bytes
`define AXIL_ADDR_W 7
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// word index starts above the byte lanes
`define AXIL_ADDR_LSB 2

`define AXIL_REG_COUNT 32

// AXI response code for a normal access
`define AXIL_RESP_OKAY 0

`endif
